// ==== source/smartnic_pkg.sv ====
package smartnic_pkg;

    // ------------------------------------------------------------
    // ingress destination codes.
    // ------------------------------------------------------------
    typedef logic [1:0] igr_tdest_t;

    localparam igr_tdest_t APP    = 2'd0;
    localparam igr_tdest_t BYPASS = 2'd1;
    localparam igr_tdest_t DROP   = 2'd2;
    // code 3 falls through to app.

    // ------------------------------------------------------------
    // port identifiers.
    // ------------------------------------------------------------
    typedef logic [0:0] port_id_t;

    // ------------------------------------------------------------
    // ingress arbiter states.
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,
        CMAC_PKT,
        HOST_PKT
    } arb_state_t;

endpackage

// ==== source/axis_pkg.sv ====
package axis_pkg;

    // stream beat width in bytes.
    localparam int DATA_BYTES = 8;

    // beat payload.
    typedef logic [8*DATA_BYTES-1:0] tdata_t;

    // one bit per valid byte.
    typedef logic [DATA_BYTES-1:0] tkeep_t;

endpackage

// ==== source/igr_arbiter.sv ====
`timescale 1ns/1ps

module igr_arbiter #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                      core_clk,
    input  logic                      srst,

    input  logic                      cmac_tvalid,
    output logic                      cmac_tready,
    input  axis_pkg::tdata_t          cmac_tdata,
    input  axis_pkg::tkeep_t          cmac_tkeep,
    input  logic                      cmac_tlast,
    input  smartnic_pkg::port_id_t    cmac_tid,

    input  logic                      host_tvalid,
    output logic                      host_tready,
    input  axis_pkg::tdata_t          host_tdata,
    input  axis_pkg::tkeep_t          host_tkeep,
    input  logic                      host_tlast,
    input  smartnic_pkg::port_id_t    host_tid,

    input  smartnic_pkg::igr_tdest_t  mux_out_sel_cmac,
    input  smartnic_pkg::igr_tdest_t  mux_out_sel_host,

    output logic                      wr_en,
    output axis_pkg::tdata_t          wr_tdata,
    output axis_pkg::tkeep_t          wr_tkeep,
    output logic                      wr_tlast,
    output smartnic_pkg::port_id_t    wr_tid,
    output smartnic_pkg::igr_tdest_t  wr_tdest,
    input  logic                      credit_return
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    smartnic_pkg::arb_state_t  state;
    logic                      last_host;
    logic                      arb_en;
    logic                      sop_cmac;
    logic                      sop_host;
    smartnic_pkg::igr_tdest_t  dest_cmac;
    smartnic_pkg::igr_tdest_t  dest_host;
    smartnic_pkg::igr_tdest_t  cur_dest_cmac;
    smartnic_pkg::igr_tdest_t  cur_dest_host;
    logic [CNT_W-1:0]          credit_cnt;
    logic                      can_accept;
    logic                      grant_cmac;
    logic                      grant_host;
    logic                      cmac_xfer;
    logic                      host_xfer;

    // ------------------------------------------------------------
    // grant and ready.
    // ------------------------------------------------------------
    // round robin at packet boundaries.
    assign grant_cmac = cmac_tvalid && (last_host || !host_tvalid);
    assign grant_host = host_tvalid && !grant_cmac;

    // a write still in flight has already spent its credit.
    assign can_accept = arb_en && (credit_cnt > CNT_W'(wr_en));

    assign cmac_tready = can_accept &&
                         ((state == smartnic_pkg::CMAC_PKT) ||
                          ((state == smartnic_pkg::IDLE) && grant_cmac));
    assign host_tready = can_accept &&
                         ((state == smartnic_pkg::HOST_PKT) ||
                          ((state == smartnic_pkg::IDLE) && grant_host));

    assign cmac_xfer = cmac_tvalid && cmac_tready;
    assign host_xfer = host_tvalid && host_tready;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            state     <= smartnic_pkg::IDLE;
            last_host <= 1'b1;
        end else begin
            case (state)
                smartnic_pkg::IDLE: begin
                    if (cmac_xfer) begin
                        last_host <= 1'b0;
                        if (!cmac_tlast) state <= smartnic_pkg::CMAC_PKT;
                    end else if (host_xfer) begin
                        last_host <= 1'b1;
                        if (!host_tlast) state <= smartnic_pkg::HOST_PKT;
                    end
                end
                smartnic_pkg::CMAC_PKT: begin
                    if (cmac_xfer && cmac_tlast) state <= smartnic_pkg::IDLE;
                end
                smartnic_pkg::HOST_PKT: begin
                    if (host_xfer && host_tlast) state <= smartnic_pkg::IDLE;
                end
                default: state <= smartnic_pkg::IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // start of packet and destination latch.
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (srst) begin
            sop_cmac <= 1'b1;
            sop_host <= 1'b1;
        end else begin
            if (cmac_xfer) sop_cmac <= cmac_tlast;
            if (host_xfer) sop_host <= host_tlast;
        end
    end

    always_ff @(posedge core_clk) begin
        if (cmac_xfer && sop_cmac) dest_cmac <= mux_out_sel_cmac;
        if (host_xfer && sop_host) dest_host <= mux_out_sel_host;
    end

    // first beat takes the live select, later beats the latched one.
    assign cur_dest_cmac = sop_cmac ? mux_out_sel_cmac : dest_cmac;
    assign cur_dest_host = sop_host ? mux_out_sel_host : dest_host;

    // ------------------------------------------------------------
    // credits.
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (srst) begin
            credit_cnt <= CNT_W'(FIFO_DEPTH);
            arb_en     <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - CNT_W'(wr_en) + CNT_W'(credit_return);
            arb_en     <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // write stage.
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (srst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= cmac_xfer || host_xfer;
        end
    end

    always_ff @(posedge core_clk) begin
        if (host_xfer) begin
            wr_tdata <= host_tdata;
            wr_tkeep <= host_tkeep;
            wr_tlast <= host_tlast;
            wr_tid   <= host_tid;
            wr_tdest <= cur_dest_host;
        end else if (cmac_xfer) begin
            wr_tdata <= cmac_tdata;
            wr_tkeep <= cmac_tkeep;
            wr_tlast <= cmac_tlast;
            wr_tid   <= cmac_tid;
            wr_tdest <= cur_dest_cmac;
        end
    end

endmodule

// ==== source/igr_fifo.sv ====
`timescale 1ns/1ps

module igr_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                      core_clk,
    input  logic                      srst,

    input  logic                      wr_en,
    input  axis_pkg::tdata_t          wr_tdata,
    input  axis_pkg::tkeep_t          wr_tkeep,
    input  logic                      wr_tlast,
    input  smartnic_pkg::port_id_t    wr_tid,
    input  smartnic_pkg::igr_tdest_t  wr_tdest,

    output logic                      rd_valid,
    output axis_pkg::tdata_t          rd_tdata,
    output axis_pkg::tkeep_t          rd_tkeep,
    output logic                      rd_tlast,
    output smartnic_pkg::port_id_t    rd_tid,
    output smartnic_pkg::igr_tdest_t  rd_tdest,
    input  logic                      rd_en,

    output logic                      credit_return
);

    localparam int AW     = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int BEAT_W = $bits(axis_pkg::tdata_t) + $bits(axis_pkg::tkeep_t) + 1 +
                            $bits(smartnic_pkg::port_id_t) + $bits(smartnic_pkg::igr_tdest_t);

    logic [BEAT_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;

    assign rd_valid = (count != '0);
    assign pop      = rd_en && rd_valid;

    // credits bound the writes to the free slots.
    always_ff @(posedge core_clk) begin
        if (wr_en) mem[wr_ptr] <= {wr_tdata, wr_tkeep, wr_tlast, wr_tid, wr_tdest};
    end

    assign {rd_tdata, rd_tkeep, rd_tlast, rd_tid, rd_tdest} = mem[rd_ptr];

    // pointers wrap on the power of two depth.
    always_ff @(posedge core_clk) begin
        if (srst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (pop)   rd_ptr <= rd_ptr + 1'b1;
            count         <= count + CNT_W'(wr_en) - CNT_W'(pop);
            credit_return <= pop;
        end
    end

endmodule

// ==== source/igr_steer.sv ====
`timescale 1ns/1ps

module igr_steer (
    input  logic                      rd_valid,
    input  axis_pkg::tdata_t          rd_tdata,
    input  axis_pkg::tkeep_t          rd_tkeep,
    input  logic                      rd_tlast,
    input  smartnic_pkg::port_id_t    rd_tid,
    input  smartnic_pkg::igr_tdest_t  rd_tdest,
    output logic                      rd_en,

    output logic                      app_tvalid,
    input  logic                      app_tready,
    output axis_pkg::tdata_t          app_tdata,
    output axis_pkg::tkeep_t          app_tkeep,
    output logic                      app_tlast,
    output smartnic_pkg::port_id_t    app_tid,
    output smartnic_pkg::igr_tdest_t  app_tdest,

    output logic                      bypass_tvalid,
    input  logic                      bypass_tready,
    output axis_pkg::tdata_t          bypass_tdata,
    output axis_pkg::tkeep_t          bypass_tkeep,
    output logic                      bypass_tlast,
    output smartnic_pkg::port_id_t    bypass_tid,
    output smartnic_pkg::igr_tdest_t  bypass_tdest,

    input  logic                      tpause
);

    logic to_bypass;

    // drop packets leave on bypass too.
    assign to_bypass = (rd_tdest == smartnic_pkg::BYPASS) || (rd_tdest == smartnic_pkg::DROP);

    assign app_tvalid    = rd_valid && !to_bypass;
    assign bypass_tvalid = rd_valid && to_bypass && !tpause;

    // a paused head beat stays in the fifo.
    assign rd_en = (app_tvalid && app_tready) || (bypass_tvalid && bypass_tready);

    assign app_tdata = rd_tdata;
    assign app_tkeep = rd_tkeep;
    assign app_tlast = rd_tlast;
    assign app_tid   = rd_tid;
    // back toward the packet's own port.
    assign app_tdest = smartnic_pkg::igr_tdest_t'(rd_tid);

    assign bypass_tdata = rd_tdata;
    assign bypass_tkeep = rd_tkeep;
    assign bypass_tlast = rd_tlast;
    assign bypass_tid   = rd_tid;
    assign bypass_tdest = rd_tdest;

endmodule

// ==== source/smartnic_igr_top.sv ====
`timescale 1ns/1ps

module smartnic_igr_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                      core_clk,
    input  logic                      srst,

    input  logic                      cmac_tvalid,
    output logic                      cmac_tready,
    input  axis_pkg::tdata_t          cmac_tdata,
    input  axis_pkg::tkeep_t          cmac_tkeep,
    input  logic                      cmac_tlast,
    input  smartnic_pkg::port_id_t    cmac_tid,

    input  logic                      host_tvalid,
    output logic                      host_tready,
    input  axis_pkg::tdata_t          host_tdata,
    input  axis_pkg::tkeep_t          host_tkeep,
    input  logic                      host_tlast,
    input  smartnic_pkg::port_id_t    host_tid,

    input  smartnic_pkg::igr_tdest_t  mux_out_sel_cmac,
    input  smartnic_pkg::igr_tdest_t  mux_out_sel_host,
    input  logic                      tpause,

    output logic                      app_tvalid,
    input  logic                      app_tready,
    output axis_pkg::tdata_t          app_tdata,
    output axis_pkg::tkeep_t          app_tkeep,
    output logic                      app_tlast,
    output smartnic_pkg::port_id_t    app_tid,
    output smartnic_pkg::igr_tdest_t  app_tdest,

    output logic                      bypass_tvalid,
    input  logic                      bypass_tready,
    output axis_pkg::tdata_t          bypass_tdata,
    output axis_pkg::tkeep_t          bypass_tkeep,
    output logic                      bypass_tlast,
    output smartnic_pkg::port_id_t    bypass_tid,
    output smartnic_pkg::igr_tdest_t  bypass_tdest
);

    // ------------------------------------------------------------
    // credit link, arbiter to fifo.
    // ------------------------------------------------------------
    logic                      wr_en;
    axis_pkg::tdata_t          wr_tdata;
    axis_pkg::tkeep_t          wr_tkeep;
    logic                      wr_tlast;
    smartnic_pkg::port_id_t    wr_tid;
    smartnic_pkg::igr_tdest_t  wr_tdest;
    logic                      credit_return;

    // ------------------------------------------------------------
    // fifo head, fifo to steer.
    // ------------------------------------------------------------
    logic                      rd_valid;
    axis_pkg::tdata_t          rd_tdata;
    axis_pkg::tkeep_t          rd_tkeep;
    logic                      rd_tlast;
    smartnic_pkg::port_id_t    rd_tid;
    smartnic_pkg::igr_tdest_t  rd_tdest;
    logic                      rd_en;

    igr_arbiter #(.FIFO_DEPTH(FIFO_DEPTH)) u_arbiter (
        .core_clk, .srst,
        .cmac_tvalid, .cmac_tready, .cmac_tdata, .cmac_tkeep, .cmac_tlast, .cmac_tid,
        .host_tvalid, .host_tready, .host_tdata, .host_tkeep, .host_tlast, .host_tid,
        .mux_out_sel_cmac, .mux_out_sel_host,
        .wr_en, .wr_tdata, .wr_tkeep, .wr_tlast, .wr_tid, .wr_tdest,
        .credit_return
    );

    igr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .core_clk, .srst,
        .wr_en, .wr_tdata, .wr_tkeep, .wr_tlast, .wr_tid, .wr_tdest,
        .rd_valid, .rd_tdata, .rd_tkeep, .rd_tlast, .rd_tid, .rd_tdest,
        .rd_en,
        .credit_return
    );

    igr_steer u_steer (
        .rd_valid, .rd_tdata, .rd_tkeep, .rd_tlast, .rd_tid, .rd_tdest, .rd_en,
        .app_tvalid, .app_tready, .app_tdata, .app_tkeep, .app_tlast, .app_tid, .app_tdest,
        .bypass_tvalid, .bypass_tready, .bypass_tdata, .bypass_tkeep, .bypass_tlast,
        .bypass_tid, .bypass_tdest,
        .tpause
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 10
) (
    output logic core_clk,
    output logic srst
);

    initial begin
        core_clk = 1'b0;
        forever #HALF_PERIOD core_clk = ~core_clk;
    end

    // release away from the sampling edge.
    initial begin
        srst = 1'b1;
        repeat (RESET_CYCLES) @(posedge core_clk);
        @(negedge core_clk);
        srst = 1'b0;
    end

endmodule

// ==== sim/smartnic_igr_assertions.sv ====
`timescale 1ns/1ps

module smartnic_igr_assertions #(
    parameter int FIFO_DEPTH = 8
) (
    input logic              core_clk,
    input logic              srst,
    input logic              wr_en,
    input logic              credit_return,
    input logic              app_tvalid,
    input logic              app_tready,
    input axis_pkg::tdata_t  app_tdata,
    input logic              bypass_tvalid,
    input logic              bypass_tready,
    input axis_pkg::tdata_t  bypass_tdata,
    input logic              tpause
);

    // shadow of the arbiter credit count.
    int credits;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            credits <= FIFO_DEPTH;
        end else begin
            credits <= credits - int'(wr_en) + int'(credit_return);
        end
    end

    credit_left: assert property (@(posedge core_clk) disable iff (srst)
        wr_en |-> credits > 0)
        else $error("buffer write with no credit left");

    app_hold: assert property (@(posedge core_clk) disable iff (srst)
        app_tvalid && !app_tready |=> app_tvalid && $stable(app_tdata))
        else $error("app beat changed or dropped before its transfer");

    // a pause may withdraw the waiting beat.
    bypass_hold: assert property (@(posedge core_clk) disable iff (srst)
        bypass_tvalid && !bypass_tready |=> tpause || (bypass_tvalid && $stable(bypass_tdata)))
        else $error("bypass beat changed or dropped before its transfer");

    pause_quiet: assert property (@(posedge core_clk) disable iff (srst)
        tpause |-> !bypass_tvalid)
        else $error("bypass valid while paused");

endmodule

bind smartnic_igr_top smartnic_igr_assertions #(.FIFO_DEPTH(FIFO_DEPTH)) u_assertions (
    .core_clk,
    .srst,
    .wr_en,
    .credit_return,
    .app_tvalid,
    .app_tready,
    .app_tdata,
    .bypass_tvalid,
    .bypass_tready,
    .bypass_tdata,
    .tpause
);

// ==== sim/tb_smartnic_igr.sv ====
`timescale 1ns/1ps

module tb_smartnic_igr;

    localparam int FIFO_DEPTH = 8;
    localparam int NUM_PKTS   = 40;
    localparam int MAX_BEATS  = 6;

    typedef struct packed {
        axis_pkg::tdata_t          data;
        axis_pkg::tkeep_t          keep;
        logic                      last;
        smartnic_pkg::igr_tdest_t  dest;
    } beat_t;

    logic                      core_clk;
    logic                      srst;
    logic                      cmac_tvalid;
    logic                      cmac_tready;
    axis_pkg::tdata_t          cmac_tdata;
    axis_pkg::tkeep_t          cmac_tkeep;
    logic                      cmac_tlast;
    smartnic_pkg::port_id_t    cmac_tid;
    logic                      host_tvalid;
    logic                      host_tready;
    axis_pkg::tdata_t          host_tdata;
    axis_pkg::tkeep_t          host_tkeep;
    logic                      host_tlast;
    smartnic_pkg::port_id_t    host_tid;
    smartnic_pkg::igr_tdest_t  mux_out_sel_cmac;
    smartnic_pkg::igr_tdest_t  mux_out_sel_host;
    logic                      tpause;
    logic                      app_tvalid;
    logic                      app_tready;
    axis_pkg::tdata_t          app_tdata;
    axis_pkg::tkeep_t          app_tkeep;
    logic                      app_tlast;
    smartnic_pkg::port_id_t    app_tid;
    smartnic_pkg::igr_tdest_t  app_tdest;
    logic                      bypass_tvalid;
    logic                      bypass_tready;
    axis_pkg::tdata_t          bypass_tdata;
    axis_pkg::tkeep_t          bypass_tkeep;
    logic                      bypass_tlast;
    smartnic_pkg::port_id_t    bypass_tid;
    smartnic_pkg::igr_tdest_t  bypass_tdest;

    beat_t                     stim_q [2][$];
    smartnic_pkg::igr_tdest_t  code_q [2][$];
    // indexed by source * 2 + output with app as 0.
    beat_t                     exp_q [4][$];

    int                        errors      = 0;
    int                        beats_seen  = 0;
    int                        total_beats = 0;
    int                        cycle_limit = 0;
    int                        cycles      = 0;
    logic                      input_seen;
    logic                      in_pkt [2];
    smartnic_pkg::port_id_t    pkt_src [2];

    tb_clk_gen u_clk_gen (.core_clk, .srst);

    smartnic_igr_top #(.FIFO_DEPTH(FIFO_DEPTH)) UUT (
        .core_clk, .srst,
        .cmac_tvalid, .cmac_tready, .cmac_tdata, .cmac_tkeep, .cmac_tlast, .cmac_tid,
        .host_tvalid, .host_tready, .host_tdata, .host_tkeep, .host_tlast, .host_tid,
        .mux_out_sel_cmac, .mux_out_sel_host, .tpause,
        .app_tvalid, .app_tready, .app_tdata, .app_tkeep, .app_tlast, .app_tid, .app_tdest,
        .bypass_tvalid, .bypass_tready, .bypass_tdata, .bypass_tkeep, .bypass_tlast,
        .bypass_tid, .bypass_tdest
    );

    // ------------------------------------------------------------
    // reference model.
    // ------------------------------------------------------------
    // only bypass and drop codes leave on bypass.
    function automatic int out_for_code(input smartnic_pkg::igr_tdest_t code);
        if (code == 2'd1 || code == 2'd2) begin
            return 1;
        end
        return 0;
    endfunction

    function automatic smartnic_pkg::igr_tdest_t random_sel();
        return smartnic_pkg::igr_tdest_t'($urandom_range(0, 3));
    endfunction

    task automatic build_stimulus();
        int                        src;
        int                        p;
        int                        b;
        int                        len;
        int                        out;
        smartnic_pkg::igr_tdest_t  code;
        beat_t                     bt;
        for (src = 0; src < 2; src++) begin
            for (p = 0; p < NUM_PKTS; p++) begin
                len  = $urandom_range(1, MAX_BEATS);
                code = random_sel();
                out  = out_for_code(code);
                code_q[src].push_back(code);
                for (b = 0; b < len; b++) begin
                    bt.data = {$urandom(), $urandom()};
                    bt.keep = axis_pkg::tkeep_t'($urandom_range(1, 255));
                    bt.last = (b == len - 1);
                    // app sends the packet back toward its own port.
                    bt.dest = (out == 1) ? code : smartnic_pkg::igr_tdest_t'(src);
                    stim_q[src].push_back(bt);
                    exp_q[src * 2 + out].push_back(bt);
                    total_beats++;
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // input drivers.
    // ------------------------------------------------------------
    task automatic set_source(input int src, input logic valid, input axis_pkg::tdata_t data,
                              input axis_pkg::tkeep_t keep, input logic last,
                              input smartnic_pkg::igr_tdest_t sel);
        if (src == 0) begin
            cmac_tvalid      = valid;
            cmac_tdata       = data;
            cmac_tkeep       = keep;
            cmac_tlast       = last;
            mux_out_sel_cmac = sel;
        end else begin
            host_tvalid      = valid;
            host_tdata       = data;
            host_tkeep       = keep;
            host_tlast       = last;
            mux_out_sel_host = sel;
        end
    endtask

    task automatic drive_source(input int src);
        beat_t                     bt;
        logic                      first;
        smartnic_pkg::igr_tdest_t  sel;
        first = 1'b1;
        while (stim_q[src].size() > 0) begin
            bt = stim_q[src].pop_front();
            @(negedge core_clk);
            if ($urandom_range(0, 3) == 0) begin
                set_source(src, 1'b0, '0, '0, 1'b0, random_sel());
                @(negedge core_clk);
            end
            // later beats see a wandering select.
            if (first) begin
                sel = code_q[src].pop_front();
            end else begin
                sel = random_sel();
            end
            set_source(src, 1'b1, bt.data, bt.keep, bt.last, sel);
            #1;
            while (!((src == 0) ? cmac_tready : host_tready)) begin
                @(negedge core_clk);
                #1;
            end
            input_seen = 1'b1;
            first      = bt.last;
        end
        @(negedge core_clk);
        set_source(src, 1'b0, '0, '0, 1'b0, random_sel());
    endtask

    // ------------------------------------------------------------
    // output checks.
    // ------------------------------------------------------------
    task automatic report_mismatch(input string sig, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("error: time %0t signal %s expected %h got %h", $time, sig, expected, actual);
    endtask

    task automatic check_beat(input int out, input axis_pkg::tdata_t data,
                              input axis_pkg::tkeep_t keep, input logic last,
                              input smartnic_pkg::port_id_t tid,
                              input smartnic_pkg::igr_tdest_t dest);
        string  name;
        int     qi;
        beat_t  exp;
        name = (out == 0) ? "app" : "bypass";
        if (in_pkt[out] && tid != pkt_src[out]) begin
            report_mismatch({name, "_tid"}, 64'(pkt_src[out]), 64'(tid));
        end
        qi = int'(tid) * 2 + out;
        if (exp_q[qi].size() == 0) begin
            errors++;
            $display("unexpected beat on %s from source %0d at time %0t", name, tid, $time);
        end else begin
            exp = exp_q[qi].pop_front();
            if (data != exp.data) report_mismatch({name, "_tdata"}, exp.data, data);
            if (keep != exp.keep) report_mismatch({name, "_tkeep"}, 64'(exp.keep), 64'(keep));
            if (last != exp.last) report_mismatch({name, "_tlast"}, 64'(exp.last), 64'(last));
            if (dest != exp.dest) report_mismatch({name, "_tdest"}, 64'(exp.dest), 64'(dest));
        end
        in_pkt[out]  = !last;
        pkt_src[out] = tid;
        beats_seen++;
    endtask

    task automatic finish_run();
        int i;
        for (i = 0; i < 4; i++) begin
            if (exp_q[i].size() != 0) begin
                errors++;
                $display("missing packets: %0d beats from %s never left the %s port",
                         exp_q[i].size(), (i / 2 == 0) ? "cmac" : "host",
                         (i % 2 == 0) ? "app" : "bypass");
            end
        end
        $display("beats checked %0d of %0d, errors %0d", beats_seen, total_beats, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // ------------------------------------------------------------
    // processes.
    // ------------------------------------------------------------
    initial begin
        void'($urandom(77713));
        set_source(0, 1'b0, '0, '0, 1'b0, '0);
        set_source(1, 1'b0, '0, '0, 1'b0, '0);
        cmac_tid      = 1'b0;
        host_tid      = 1'b1;
        tpause        = 1'b0;
        app_tready    = 1'b0;
        bypass_tready = 1'b0;
        input_seen    = 1'b0;
        in_pkt[0]     = 1'b0;
        in_pkt[1]     = 1'b0;
        pkt_src[0]    = 1'b0;
        pkt_src[1]    = 1'b0;
        build_stimulus();
        cycle_limit = 20 * total_beats + 200;
        @(negedge srst);
        fork
            drive_source(0);
            drive_source(1);
        join
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0) begin
            @(negedge core_clk);
        end
        // a duplicated beat would show in the idle tail.
        repeat (10) @(negedge core_clk);
        finish_run();
    end

    initial begin
        @(negedge srst);
        forever begin
            @(negedge core_clk);
            app_tready    = ($urandom_range(0, 3) != 0);
            bypass_tready = ($urandom_range(0, 3) != 0);
            tpause        = ($urandom_range(0, 7) == 0);
            #1;
            if (tpause && bypass_tvalid) begin
                errors++;
                $display("bypass port offered a beat while paused at time %0t", $time);
            end
            if (!input_seen && (app_tvalid || bypass_tvalid)) begin
                errors++;
                $display("output valid before any input beat at time %0t", $time);
            end
            if (app_tvalid && app_tready) begin
                check_beat(0, app_tdata, app_tkeep, app_tlast, app_tid, app_tdest);
            end
            if (bypass_tvalid && bypass_tready) begin
                check_beat(1, bypass_tdata, bypass_tkeep, bypass_tlast, bypass_tid, bypass_tdest);
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge core_clk);
            cycles++;
        end
        errors++;
        $display("timeout: packets still in flight after %0d cycles", cycle_limit);
        finish_run();
    end

endmodule

// ==== vlog.f ====
source/smartnic_pkg.sv
source/axis_pkg.sv
source/igr_arbiter.sv
source/igr_fifo.sv
source/igr_steer.sv
source/smartnic_igr_top.sv
sim/tb_clk_gen.sv
sim/smartnic_igr_assertions.sv
sim/tb_smartnic_igr.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_smartnic_igr -f vlog.f -o sim_igr || exit 1
./obj_dir/sim_igr > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
